/* mem_1r1w_top.f */
+incdir+.
mem_pkg.sv
bank_cmd_if.sv
remap_table.sv
bank_array.sv
read_return.sv
mem_1r1w_top.sv
tb_mem_1r1w.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the 1R1W memory testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_mem_1r1w \
  -f mem_1r1w_top.f \
  -o sim_mem_1r1w

./obj_dir/sim_mem_1r1w | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* tb_mem_1r1w.sv */
`timescale 1ns/10ps
`include "mem_params.svh"

module tb_mem_1r1w;

  localparam int CLK_PERIOD = 4;
  localparam int MAX_ROWS   = 512;
  localparam int NUM_ADDR   = 1 << `BITADDR;
  localparam int RET_DELAY  = 3;  // drive edge to visible rd_vld.

  logic                clk = 1'b0;
  logic                rst_n;
  logic                read;
  logic [`BITADDR-1:0] rd_addr;
  logic                write;
  logic [`BITADDR-1:0] wr_addr;
  logic [`WIDTH-1:0]   din;
  logic                ready;
  logic                rd_vld;
  logic [`WIDTH-1:0]   rd_dout;

  // stimulus table.
  string               tbl_name  [MAX_ROWS];
  logic                tbl_read  [MAX_ROWS];
  logic [`BITADDR-1:0] tbl_raddr [MAX_ROWS];
  logic                tbl_write [MAX_ROWS];
  logic [`BITADDR-1:0] tbl_waddr [MAX_ROWS];
  logic [`WIDTH-1:0]   tbl_din   [MAX_ROWS];
  int                  num_rows = 0;

  // reference model and expected returns per table row.
  logic [`WIDTH-1:0]   model_mem [NUM_ADDR];
  logic                exp_vld   [MAX_ROWS];
  logic [`WIDTH-1:0]   exp_data  [MAX_ROWS];

  int     checks      = 0;
  int     errors      = 0;
  integer seed        = 4217;
  logic   table_built = 1'b0;

  mem_1r1w_top DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .read    (read),
    .rd_addr (rd_addr),
    .write   (write),
    .wr_addr (wr_addr),
    .din     (din),
    .ready   (ready),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ======================================================================
  // helpers
  // ======================================================================

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // low bits pick the logical bank, upper bits the row.
  function automatic logic [`BITADDR-1:0] addr_of(input int row, input int vbnk);
    return `BITADDR'(row * `NUMVBNK + vbnk);
  endfunction

  task automatic add_row(input string name, input logic rd, input logic [`BITADDR-1:0] ra,
                         input logic wr, input logic [`BITADDR-1:0] wa,
                         input logic [`WIDTH-1:0] d);
    if (num_rows >= MAX_ROWS) begin
      errors++;
      $display("stimulus table is full, row %s dropped", name);
    end else begin
      tbl_name[num_rows]  = name;
      tbl_read[num_rows]  = rd;
      tbl_raddr[num_rows] = ra;
      tbl_write[num_rows] = wr;
      tbl_waddr[num_rows] = wa;
      tbl_din[num_rows]   = d;
      num_rows++;
    end
  endtask

  task automatic build_table();
    integer rnd;
    for (int a = 0; a < NUM_ADDR; a++) begin
      add_row("preload", 1'b0, '0, 1'b1, `BITADDR'(a), `WIDTH'(32'h1000 + a * 17));
    end
    // one read then one idle cycle, so rd_vld pulses.
    for (int a = 0; a < NUM_ADDR; a++) begin
      add_row($sformatf("readback[%0d]", a), 1'b1, `BITADDR'(a), 1'b0, '0, '0);
      add_row("idle", 1'b0, '0, 1'b0, '0, '0);
    end
    // row 5 writes collide with row 1 reads, walking the spare bank.
    for (int v = 0; v < `NUMVBNK; v++) begin
      add_row($sformatf("conflict[%0d]", v), 1'b1, addr_of(1, v), 1'b1, addr_of(5, v),
              `WIDTH'(32'hc000 + v));
    end
    add_row("conflict[4]", 1'b1, addr_of(1, 0), 1'b1, addr_of(5, 1), `WIDTH'(16'hc0f5));
    for (int v = 0; v < `NUMVBNK; v++) begin
      add_row($sformatf("conflict_wr_back[%0d]", v), 1'b1, addr_of(5, v), 1'b0, '0, '0);
      add_row($sformatf("conflict_rd_back[%0d]", v), 1'b1, addr_of(1, v), 1'b0, '0, '0);
    end
    add_row("same_addr_rw", 1'b1, 7'd50, 1'b1, 7'd50, 16'hbeef);
    add_row("same_addr_next", 1'b1, 7'd50, 1'b0, '0, '0);
    add_row("idle", 1'b0, '0, 1'b0, '0, '0);
    for (int a = 96; a < 104; a++) begin
      add_row($sformatf("back_to_back[%0d]", a), 1'b1, `BITADDR'(a), 1'b0, '0, '0);
    end
    for (int i = 0; i < 64; i++) begin
      rnd = $random(seed);
      add_row($sformatf("random[%0d]", i), rnd[0], rnd[8:2], rnd[1], rnd[15:9],
              rnd[31:16]);
    end
    table_built = 1'b1;
  endtask

  // reads are driven during the sweep and must be dropped.
  task automatic wait_for_ready();
    int wait_cycles;
    wait_cycles = 0;
    while (!ready && wait_cycles < `NUMVROW + 1) begin
      @(posedge clk);
      read    <= (wait_cycles < `NUMVROW / 2);
      rd_addr <= `BITADDR'(wait_cycles);
      @(negedge clk);
      wait_cycles++;
      check_value("init_no_rd_vld", 32'd0, 32'(rd_vld));
    end
    if (!ready) begin
      errors++;
      $display("ready did not rise within %0d cycles of reset release", `NUMVROW + 1);
    end
  endtask

  task automatic drive_row(input int j);
    if (j < num_rows) begin
      read     <= tbl_read[j];
      rd_addr  <= tbl_raddr[j];
      write    <= tbl_write[j];
      wr_addr  <= tbl_waddr[j];
      din      <= tbl_din[j];
      // same cycle read sees the old word.
      exp_vld[j]  = tbl_read[j];
      exp_data[j] = model_mem[tbl_raddr[j]];
      if (tbl_write[j]) begin
        model_mem[tbl_waddr[j]] = tbl_din[j];
      end
    end else begin
      read  <= 1'b0;
      write <= 1'b0;
    end
  endtask

  task automatic check_return(input int j);
    int    k;
    logic  vld;
    string name;
    k = j - RET_DELAY;
    vld  = (k >= 0) ? exp_vld[k] : 1'b0;
    name = (k >= 0) ? tbl_name[k] : "startup";
    check_value({name, " rd_vld"}, 32'(vld), 32'(rd_vld));
    if (vld) begin
      check_value({name, " rd_dout"}, 32'(exp_data[k]), 32'(rd_dout));
    end
  endtask

  // ======================================================================
  // main sequence
  // ======================================================================

  initial begin
    rst_n   = 1'b0;
    read    = 1'b0;
    rd_addr = '0;
    write   = 1'b0;
    wr_addr = '0;
    din     = '0;
    build_table();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    wait_for_ready();
    for (int j = 0; j < num_rows + RET_DELAY; j++) begin
      @(posedge clk);
      drive_row(j);
      @(negedge clk);
      check_return(j);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    int limit;
    wait (table_built);
    limit = 3 + `NUMVROW + num_rows + 20;
    #(limit * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* mem_1r1w_top.sv */
`timescale 1ns/10ps
`include "mem_params.svh"

module mem_1r1w_top import mem_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                read,
  input  logic [`BITADDR-1:0] rd_addr,
  input  logic                write,
  input  logic [`BITADDR-1:0] wr_addr,
  input  logic [`WIDTH-1:0]   din,
  output logic                ready,
  output logic                rd_vld,
  output logic [`WIDTH-1:0]   rd_dout
);

  word_t [`NUMPBNK-1:0] bank_dout;

  bank_cmd_if cmd_if ();

  // ======================================================================
  // remap table, banks and read return
  // ======================================================================

  remap_table u_table (
    .clk     (clk),
    .rst_n   (rst_n),
    .read    (read),
    .rd_addr (rd_addr),
    .write   (write),
    .wr_addr (wr_addr),
    .din     (din),
    .ready   (ready),
    .cmd     (cmd_if)
  );

  bank_array u_banks (
    .clk       (clk),
    .cmd       (cmd_if),
    .bank_dout (bank_dout)
  );

  read_return u_return (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd_if),
    .bank_dout (bank_dout),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout)
  );

endmodule

/* read_return.sv */
`timescale 1ns/10ps
`include "mem_params.svh"

module read_return import mem_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  bank_cmd_if.return_side      cmd,
  input  word_t [`NUMPBNK-1:0] bank_dout,
  output logic                 rd_vld,
  output word_t                rd_dout
);

  logic [`SRAM_DELAY-1:0] vld_pipe;
  pbnk_t                  pbnk_pipe [`SRAM_DELAY];
  logic                   ret_vld;
  pbnk_t                  ret_pbnk;

  // tag of the read whose data sits on the bank outputs now.
  assign ret_vld  = vld_pipe[`SRAM_DELAY-1];
  assign ret_pbnk = pbnk_pipe[`SRAM_DELAY-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_pipe <= '0;
      rd_vld   <= 1'b0;
    end else begin
      vld_pipe[0] <= cmd.rd_en;
      for (int i = 1; i < `SRAM_DELAY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
      rd_vld <= ret_vld;
    end
  end

  always_ff @(posedge clk) begin
    pbnk_pipe[0] <= cmd.rd_pbnk;
    for (int i = 1; i < `SRAM_DELAY; i++) begin
      pbnk_pipe[i] <= pbnk_pipe[i-1];
    end
    if (ret_vld) begin
      rd_dout <= bank_dout[ret_pbnk];  // pick the bank that served it.
    end
  end

endmodule

/* bank_array.sv */
`timescale 1ns/10ps
`include "mem_params.svh"

module bank_array import mem_pkg::*; (
  input  logic                 clk,
  bank_cmd_if.bank_side        cmd,
  output word_t [`NUMPBNK-1:0] bank_dout
);

  // ======================================================================
  // single-port banks
  // ======================================================================

  genvar p;
  generate
    for (p = 0; p < `NUMPBNK; p++) begin : g_bank
      word_t mem [`NUMVROW];
      word_t dout_pipe [`SRAM_DELAY];
      logic  wr_sel;
      logic  rd_sel;

      assign wr_sel = cmd.wr_en && (cmd.wr_pbnk == pbnk_t'(p));
      assign rd_sel = cmd.rd_en && (cmd.rd_pbnk == pbnk_t'(p));

      // one access per cycle, table keeps read and write apart.
      always_ff @(posedge clk) begin
        if (wr_sel) begin
          mem[cmd.wr_row] <= cmd.wr_data;
        end else if (rd_sel) begin
          dout_pipe[0] <= mem[cmd.rd_row];
        end
        for (int i = 1; i < `SRAM_DELAY; i++) begin
          dout_pipe[i] <= dout_pipe[i-1];  // extra latency stages.
        end
      end

      assign bank_dout[p] = dout_pipe[`SRAM_DELAY-1];
    end
  endgenerate

endmodule

/* remap_table.sv */
`timescale 1ns/10ps
`include "mem_params.svh"

module remap_table import mem_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                read,
  input  logic [`BITADDR-1:0] rd_addr,
  input  logic                write,
  input  logic [`BITADDR-1:0] wr_addr,
  input  word_t               din,
  output logic                ready,
  bank_cmd_if.table_side      cmd
);

  table_state_t state;
  vrow_t        init_row;
  row_map_t     map_mem [`NUMVROW];
  row_map_t     init_map;

  logic                req_read;
  logic                req_write;
  logic [`BITADDR-1:0] req_raddr;
  logic [`BITADDR-1:0] req_waddr;
  word_t               req_din;

  vbnk_t    rd_vbnk;
  vrow_t    rd_row;
  vbnk_t    wr_vbnk;
  vrow_t    wr_row;
  row_map_t rd_map;
  row_map_t wr_map;
  row_map_t upd_map;
  pbnk_t    rd_cur_pbnk;
  pbnk_t    wr_cur_pbnk;
  logic     conflict;

  // ======================================================================
  // init sweep
  // ======================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= TBL_INIT;
      init_row <= '0;
    end else if (state == TBL_INIT) begin
      init_row <= init_row + 1'b1;
      if (init_row == vrow_t'(`NUMVROW - 1)) begin
        state <= TBL_RUN;  // last row written.
      end
    end
  end

  assign ready = (state == TBL_RUN);

  // logical bank i lives in physical bank i, top bank spare.
  always_comb begin
    for (int i = 0; i < `NUMVBNK; i++) begin
      init_map.vmap[i] = pbnk_t'(i);
    end
    init_map.free_pbnk = pbnk_t'(`NUMVBNK);
  end

  // ======================================================================
  // request stage
  // ======================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_read  <= 1'b0;
      req_write <= 1'b0;
    end else begin
      req_read  <= read && ready;   // dropped until the table is built.
      req_write <= write && ready;
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      req_raddr <= rd_addr;
    end
    if (write) begin
      req_waddr <= wr_addr;
      req_din   <= din;
    end
  end

  assign rd_vbnk = req_raddr[`BITVBNK-1:0];
  assign rd_row  = req_raddr[`BITADDR-1:`BITVBNK];
  assign wr_vbnk = req_waddr[`BITVBNK-1:0];
  assign wr_row  = req_waddr[`BITADDR-1:`BITVBNK];

  // ======================================================================
  // lookup and conflict resolution
  // ======================================================================

  assign rd_map      = map_mem[rd_row];
  assign wr_map      = map_mem[wr_row];
  assign rd_cur_pbnk = rd_map.vmap[rd_vbnk];
  assign wr_cur_pbnk = wr_map.vmap[wr_vbnk];

  // the read keeps its bank, the write moves to the spare.
  assign conflict = req_read && req_write && (rd_cur_pbnk == wr_cur_pbnk);

  always_comb begin
    upd_map                = wr_map;
    upd_map.vmap[wr_vbnk]  = wr_map.free_pbnk;
    upd_map.free_pbnk      = wr_cur_pbnk;  // old home becomes spare.
  end

  always_ff @(posedge clk) begin
    if (state == TBL_INIT) begin
      map_mem[init_row] <= init_map;
    end else if (req_write && conflict) begin
      map_mem[wr_row] <= upd_map;
    end
  end

  // ======================================================================
  // bank commands
  // ======================================================================

  assign cmd.rd_en   = req_read;
  assign cmd.rd_pbnk = rd_cur_pbnk;
  assign cmd.rd_row  = rd_row;

  assign cmd.wr_en   = req_write;
  assign cmd.wr_pbnk = conflict ? wr_map.free_pbnk : wr_cur_pbnk;
  assign cmd.wr_row  = wr_row;
  assign cmd.wr_data = req_din;

endmodule

/* bank_cmd_if.sv */
`timescale 1ns/10ps

interface bank_cmd_if import mem_pkg::*; ();

  logic  rd_en;
  pbnk_t rd_pbnk;
  vrow_t rd_row;

  logic  wr_en;
  pbnk_t wr_pbnk;
  vrow_t wr_row;
  word_t wr_data;

  modport table_side (
    output rd_en, rd_pbnk, rd_row,
    output wr_en, wr_pbnk, wr_row, wr_data
  );

  modport bank_side (
    input rd_en, rd_pbnk, rd_row,
    input wr_en, wr_pbnk, wr_row, wr_data
  );

  // only the read tag is needed on the return path.
  modport return_side (
    input rd_en, rd_pbnk
  );

endinterface

/* mem_pkg.sv */
`include "mem_params.svh"

package mem_pkg;

  typedef logic [`WIDTH-1:0]   word_t;
  typedef logic [`BITVBNK-1:0] vbnk_t;
  typedef logic [`BITPBNK-1:0] pbnk_t;
  typedef logic [`BITVROW-1:0] vrow_t;

  // one row of the remap table.
  typedef struct packed {
    pbnk_t [`NUMVBNK-1:0] vmap;       // physical home of each logical bank.
    pbnk_t                free_pbnk;  // spare bank for this row.
  } row_map_t;

  typedef enum logic {
    TBL_INIT,
    TBL_RUN
  } table_state_t;

endpackage

/* mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// ======================================================================
// memory geometry
// ======================================================================
`define WIDTH      16  // data word.
`define BITADDR    7
`define NUMVBNK    4   // logical banks.
`define BITVBNK    2
`define NUMPBNK    5   // one spare physical bank.
`define BITPBNK    3
`define NUMVROW    32
`define BITVROW    5

// bank read latency in cycles.
`define SRAM_DELAY 1

`endif
